/* flist.f */
hdl/bus_pkg.sv
hdl/bank_if.sv
hdl/sram_bank.sv
hdl/bus_decoder.sv
hdl/mem_bus_top.sv
testbench/bus_checker.sv
testbench/tb_top.sv

/* testbench/tb_top.sv */
module tb_top import bus_pkg::*; ();

    localparam int          NUM_REQ    = 3000;
    localparam int          MAX_CYCLES = 2 * NUM_REQ + 100;
    localparam int unsigned SEED       = 32'h89ea_9ec1;

    logic  clk_50m;
    logic  rst;
    logic  inst_req, inst_rvalid;
    addr_t inst_addr;
    word_t inst_rdata;
    logic  data_req, data_we, data_stall, data_rvalid;
    addr_t data_addr;
    word_t data_wdata, data_rdata;
    mask_t data_mask;
    int    value_errs, flag_errs;
    int    cycle_cnt;

    always #4 clk_50m = ~clk_50m;   // 8 unit period

    mem_bus_top u_dut (
        .clk_50m_i     (clk_50m),
        .rst_i         (rst),
        .inst_req_i    (inst_req),
        .inst_addr_i   (inst_addr),
        .inst_rdata_o  (inst_rdata),
        .inst_rvalid_o (inst_rvalid),
        .data_req_i    (data_req),
        .data_we_i     (data_we),
        .data_addr_i   (data_addr),
        .data_wdata_i  (data_wdata),
        .data_mask_i   (data_mask),
        .data_stall_o  (data_stall),
        .data_rdata_o  (data_rdata),
        .data_rvalid_o (data_rvalid)
    );

    bus_checker u_checker (
        .clk_i         (clk_50m),
        .rst_i         (rst),
        .inst_req_i    (inst_req),
        .inst_addr_i   (inst_addr),
        .inst_rdata_i  (inst_rdata),
        .inst_rvalid_i (inst_rvalid),
        .data_req_i    (data_req),
        .data_we_i     (data_we),
        .data_addr_i   (data_addr),
        .data_wdata_i  (data_wdata),
        .data_mask_i   (data_mask),
        .data_stall_i  (data_stall),
        .data_rdata_i  (data_rdata),
        .data_rvalid_i (data_rvalid),
        .value_err_o   (value_errs),
        .flag_err_o    (flag_errs)
    );

    // few word offsets, random high bits for aliasing
    function automatic addr_t pick_addr();
        int unsigned sel;
        logic [9:0]  hi_bits;
        logic [2:0]  idx;
        addr_t       off;
        sel     = $urandom_range(0, 9);
        hi_bits = ($urandom_range(0, 1) == 1) ? 10'($urandom_range(0, 1023)) : 10'd0;
        idx     = 3'($urandom_range(0, 7));
        off     = {10'd0, hi_bits, 7'd0, idx, 2'b00};   // bits 21:12 alias, 11:2 word
        if (sel < 4) begin
            return EXT_BASE + off;
        end else if (sel < 8) begin
            return BASE_BASE + off;
        end
        // unmapped, below, just above, far above
        case ($urandom_range(0, 2))
            0:       return 32'h0000_0000 + off;
            1:       return 32'h8080_0000 + off;
            default: return 32'hbfc0_0000 + off;
        endcase
    endfunction

    // hard limit on run length
    always @(posedge clk_50m) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int unsigned accepted;
        logic        hold;
        accepted = 0;
        void'($urandom(SEED));
        clk_50m    = 1'b0;
        rst        = 1'b1;
        cycle_cnt  = 0;
        inst_req   = 1'b0;
        inst_addr  = '0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_mask  = 4'hf;

        repeat (10) @(posedge clk_50m);
        #1;
        rst = 1'b0;

        while (accepted < NUM_REQ) begin
            @(posedge clk_50m);
            if (inst_req) accepted++;                 // fetch never stalls
            if (data_req && !data_stall) accepted++;
            hold = data_req && data_stall;            // stalled request stays put
            #1;
            inst_req  = ($urandom_range(0, 3) != 0);
            inst_addr = pick_addr();
            if (!hold) begin
                data_req   = ($urandom_range(0, 3) != 0);
                data_we    = 1'($urandom_range(0, 1));
                data_addr  = pick_addr();
                data_wdata = $urandom();
                data_mask  = 4'($urandom_range(1, 15));
            end
        end

        // drain, fetch off first so a held data request goes through
        @(posedge clk_50m);
        #1;
        inst_req = 1'b0;
        @(posedge clk_50m);
        #1;
        data_req = 1'b0;
        repeat (3) @(posedge clk_50m);

        $display("errors: value %0d, flag %0d", value_errs, flag_errs);
        if (value_errs + flag_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/bus_checker.sv */
module bus_checker import bus_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_i,

    // fetch port as seen at the DUT
    input  logic  inst_req_i,
    input  addr_t inst_addr_i,
    input  word_t inst_rdata_i,
    input  logic  inst_rvalid_i,

    // load/store port as seen at the DUT
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  addr_t data_addr_i,
    input  word_t data_wdata_i,
    input  mask_t data_mask_i,
    input  logic  data_stall_i,
    input  word_t data_rdata_i,
    input  logic  data_rvalid_i,

    output int    value_err_o,   // wrong read data
    output int    flag_err_o     // wrong rvalid or stall
);

    word_t model_mem   [2][BANK_DEPTH];   // [0] ext, [1] base
    mask_t model_known [2][BANK_DEPTH];   // bytes written so far

    // reads accepted at the last edge, due now
    logic  inst_pend, data_pend;
    word_t inst_exp, data_exp;
    mask_t inst_known, data_known;

    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                model_known[b][i] = '0;   // contents start unknown
            end
        end
        inst_pend   = 1'b0;
        data_pend   = 1'b0;
        value_err_o = 0;
        flag_err_o  = 0;
    end

    // memory map, limits exclusive
    function automatic target_t region_of(input addr_t a);
        if (a >= 32'h8000_0000 && a < 32'h8040_0000) begin
            return TGT_EXT;
        end else if (a >= 32'h8040_0000 && a < 32'h8080_0000) begin
            return TGT_BASE;
        end
        return TGT_NONE;
    endfunction

    // byte enables -> bit mask
    function automatic word_t lanes(input mask_t m);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = {8{m[i]}};
        end
        return w;
    endfunction

    task automatic predict(input target_t t, input addr_t a,
                           output word_t w, output mask_t k);
        int bank;
        if (t == TGT_NONE) begin
            w = '0;        // unmapped reads as zero
            k = 4'hf;
        end else begin
            bank = (t == TGT_EXT) ? 0 : 1;
            w = model_mem[bank][a[11:2]];     // bits 21:12 alias
            k = model_known[bank][a[11:2]];
        end
    endtask

    task automatic store(input target_t t, input addr_t a, input word_t w, input mask_t m);
        int bank;
        if (t != TGT_NONE) begin   // unmapped writes dropped
            bank = (t == TGT_EXT) ? 0 : 1;
            for (int i = 0; i < 4; i++) begin
                if (m[i]) begin
                    model_mem[bank][a[11:2]][8*i +: 8] = w[8*i +: 8];
                    model_known[bank][a[11:2]][i] = 1'b1;
                end
            end
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, got);
            flag_err_o++;
        end
    endtask

    // only bytes with a known value are compared
    task automatic check_word(input string name, input word_t exp, input mask_t k,
                              input word_t got);
        if (((got ^ exp) & lanes(k)) !== '0) begin
            $display("ERR %s exp=%08h got=%08h mask=%h", name, exp & lanes(k), got, k);
            value_err_o++;
        end
    endtask

    always @(posedge clk_i) begin : sample
        target_t inst_tgt, data_tgt;
        logic    exp_stall;
        logic    data_go;
        if (rst_i) begin
            inst_pend = 1'b0;   // nothing in flight after reset
            data_pend = 1'b0;
        end else begin
            // returns for reads accepted one edge ago
            check_flag("inst_rvalid_o", inst_pend, inst_rvalid_i);
            check_flag("data_rvalid_o", data_pend, data_rvalid_i);
            if (inst_pend) begin
                check_word("inst_rdata_o", inst_exp, inst_known, inst_rdata_i);
            end
            if (data_pend) begin
                check_word("data_rdata_o", data_exp, data_known, data_rdata_i);
            end

            inst_tgt  = region_of(inst_addr_i);
            data_tgt  = region_of(data_addr_i);
            exp_stall = inst_req_i && data_req_i
                     && (inst_tgt == data_tgt) && (inst_tgt != TGT_NONE);
            check_flag("data_stall_o", exp_stall, data_stall_i);
            data_go = data_req_i && !exp_stall;

            // acceptance at this edge, never the same bank for both
            inst_pend = inst_req_i;
            if (inst_req_i) begin
                predict(inst_tgt, inst_addr_i, inst_exp, inst_known);
            end
            data_pend = data_go && !data_we_i;   // writes give no rvalid
            if (data_go && data_we_i) begin
                store(data_tgt, data_addr_i, data_wdata_i, data_mask_i);
            end else if (data_go) begin
                predict(data_tgt, data_addr_i, data_exp, data_known);
            end
        end
    end

endmodule

/* hdl/mem_bus_top.sv */
module mem_bus_top import bus_pkg::*; (
    input  logic  clk_50m_i,
    input  logic  rst_i,

    // fetch port
    input  logic  inst_req_i,
    input  addr_t inst_addr_i,
    output word_t inst_rdata_o,
    output logic  inst_rvalid_o,

    // load/store port
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  addr_t data_addr_i,
    input  word_t data_wdata_i,
    input  mask_t data_mask_i,
    output logic  data_stall_o,
    output word_t data_rdata_o,
    output logic  data_rvalid_o
);

    // one link per bank
    bank_if ext_if ();    // 0x8000_0000 .. 0x803F_FFFF
    bank_if base_if ();   // 0x8040_0000 .. 0x807F_FFFF

    // decode, arbitrate, steer read data back
    bus_decoder u_decoder (
        .clk_50m_i     (clk_50m_i),
        .rst_i         (rst_i),
        .inst_req_i    (inst_req_i),
        .inst_addr_i   (inst_addr_i),
        .inst_rdata_o  (inst_rdata_o),
        .inst_rvalid_o (inst_rvalid_o),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_mask_i   (data_mask_i),
        .data_stall_o  (data_stall_o),
        .data_rdata_o  (data_rdata_o),
        .data_rvalid_o (data_rvalid_o),
        .ext_bank      (ext_if.master),
        .base_bank     (base_if.master)
    );

    // ext sram
    sram_bank u_ext_bank (
        .clk_50m_i (clk_50m_i),
        .bus       (ext_if.slave)
    );

    // base sram
    sram_bank u_base_bank (
        .clk_50m_i (clk_50m_i),
        .bus       (base_if.slave)
    );

endmodule

/* hdl/bus_decoder.sv */
module bus_decoder import bus_pkg::*; (
    input  logic   clk_50m_i,
    input  logic   rst_i,

    // fetch port
    input  logic   inst_req_i,
    input  addr_t  inst_addr_i,
    output word_t  inst_rdata_o,
    output logic   inst_rvalid_o,

    // load/store port
    input  logic   data_req_i,
    input  logic   data_we_i,
    input  addr_t  data_addr_i,
    input  word_t  data_wdata_i,
    input  mask_t  data_mask_i,
    output logic   data_stall_o,
    output word_t  data_rdata_o,
    output logic   data_rvalid_o,

    // banks
    bank_if.master ext_bank,
    bank_if.master base_bank
);

    // address -> target, same map for both ports
    function automatic target_t decode(input addr_t a);
        target_t t;
        if (a >= EXT_BASE && a < EXT_LIMIT) begin
            t = TGT_EXT;
        end else if (a >= BASE_BASE && a < BASE_LIMIT) begin
            t = TGT_BASE;
        end else begin
            t = TGT_NONE;
        end
        return t;
    endfunction

    target_t    inst_tgt, data_tgt;     // decoded targets this cycle
    bank_addr_t inst_idx, data_idx;     // word index, bits 11:2
    logic       data_go;                // data request accepted this edge
    logic       ext_inst_sel, ext_data_sel;
    logic       base_inst_sel, base_data_sel;

    // steering for the read return, one cycle behind acceptance
    target_t    inst_tgt_q, data_tgt_q;
    logic       inst_vld_q, data_vld_q;
    word_t      ext_rdata, base_rdata;

    assign inst_tgt = decode(inst_addr_i);
    assign data_tgt = decode(data_addr_i);
    assign inst_idx = inst_addr_i[BANK_AW+1:2];
    assign data_idx = data_addr_i[BANK_AW+1:2];

    // same mapped bank from both ports -> fetch wins, data waits
    assign data_stall_o = inst_req_i && data_req_i
                       && (inst_tgt == data_tgt) && (data_tgt != TGT_NONE);
    assign data_go = data_req_i && !data_stall_o;

    // bank grants
    assign ext_inst_sel  = inst_req_i && (inst_tgt == TGT_EXT);
    assign ext_data_sel  = data_go && (data_tgt == TGT_EXT);
    assign base_inst_sel = inst_req_i && (inst_tgt == TGT_BASE);
    assign base_data_sel = data_go && (data_tgt == TGT_BASE);

    // ext bank request mux
    assign ext_bank.req   = ext_inst_sel || ext_data_sel;
    assign ext_bank.we    = ext_data_sel && data_we_i;          // fetch never writes
    assign ext_bank.addr  = ext_inst_sel ? inst_idx : data_idx;
    assign ext_bank.wdata = data_wdata_i;
    assign ext_bank.mask  = ext_inst_sel ? MASK_FULL : data_mask_i;

    // base bank request mux
    assign base_bank.req   = base_inst_sel || base_data_sel;
    assign base_bank.we    = base_data_sel && data_we_i;
    assign base_bank.addr  = base_inst_sel ? inst_idx : data_idx;
    assign base_bank.wdata = data_wdata_i;
    assign base_bank.mask  = base_inst_sel ? MASK_FULL : data_mask_i;

    // remember who served each accepted read
    always_ff @(posedge clk_50m_i) begin
        if (rst_i) begin
            inst_vld_q <= 1'b0;
            data_vld_q <= 1'b0;
            inst_tgt_q <= TGT_NONE;
            data_tgt_q <= TGT_NONE;
        end else begin
            inst_vld_q <= inst_req_i;               // fetch is always a read
            inst_tgt_q <= inst_tgt;
            data_vld_q <= data_go && !data_we_i;    // writes give no rvalid
            data_tgt_q <= data_tgt;
        end
    end

    assign ext_rdata  = ext_bank.rdata;
    assign base_rdata = base_bank.rdata;

    // return mux, unmapped reads as zero
    function automatic word_t steer(input target_t t, input word_t e, input word_t b);
        word_t w;
        case (t)
            TGT_EXT:  w = e;
            TGT_BASE: w = b;
            default:  w = '0;
        endcase
        return w;
    endfunction

    assign inst_rdata_o  = steer(inst_tgt_q, ext_rdata, base_rdata);
    assign data_rdata_o  = steer(data_tgt_q, ext_rdata, base_rdata);
    assign inst_rvalid_o = inst_vld_q;
    assign data_rvalid_o = data_vld_q;

    // one port per bank per cycle
    a_one_port_per_bank : assert property (
        @(posedge clk_50m_i) disable iff (rst_i)
        !(ext_inst_sel && ext_data_sel) && !(base_inst_sel && base_data_sel)
    ) else $error("bus_decoder: bank granted to both ports");

    // port must keep a stalled request steady
    a_stall_hold : assert property (
        @(posedge clk_50m_i) disable iff (rst_i)
        data_stall_o |=> data_req_i
            && $stable({data_we_i, data_addr_i, data_wdata_i, data_mask_i})
    ) else $error("bus_decoder: stalled data request changed");

endmodule

/* hdl/sram_bank.sv */
module sram_bank import bus_pkg::*; (
    input  logic   clk_50m_i,
    bank_if.slave  bus
);

    localparam int NBYTES = $bits(mask_t);   // bytes per word

    word_t mem [BANK_DEPTH];   // word array, contents undefined at start

    // one access per edge, write or read
    always_ff @(posedge clk_50m_i) begin
        if (bus.req) begin
            if (bus.we) begin
                // byte lanes, untouched lanes keep old value
                for (int b = 0; b < NBYTES; b++) begin
                    if (bus.mask[b]) begin
                        mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end else begin
                bus.rdata <= mem[bus.addr];   // one cycle read latency
            end
        end
    end

    // decoder only routes writes with at least one byte enabled
    a_write_has_mask : assert property (
        @(posedge clk_50m_i) (bus.req && bus.we) |-> (bus.mask != '0)
    ) else $error("sram_bank: write request with empty mask");

endmodule

/* hdl/bank_if.sv */
interface bank_if import bus_pkg::*; ();

    logic       req;     // access at this edge
    logic       we;      // 1 write, 0 read
    bank_addr_t addr;    // word index, addr bits 11:2
    word_t      wdata;   // write word
    mask_t      mask;    // byte enables for writes
    word_t      rdata;   // registered read word, held until next read

    // decoder side
    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        output mask,
        input  rdata
    );

    // memory side
    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  mask,
        output rdata
    );

endinterface

/* hdl/bus_pkg.sv */
package bus_pkg;

    // bus widths
    typedef logic [31:0] addr_t;   // byte address from a port
    typedef logic [31:0] word_t;   // data word
    typedef logic [3:0]  mask_t;   // byte enables, bit n -> byte n

    // bank geometry
    // a bank decodes word offset bits 11:2, higher bits alias
    localparam int BANK_AW    = 10;              // word index width
    localparam int BANK_DEPTH = 1 << BANK_AW;    // 1024 words

    typedef logic [BANK_AW-1:0] bank_addr_t;     // word index inside a bank

    // region bounds, limits exclusive
    localparam addr_t EXT_BASE   = 32'h8000_0000;  // ext sram, 4 MB window
    localparam addr_t EXT_LIMIT  = 32'h8040_0000;
    localparam addr_t BASE_BASE  = 32'h8040_0000;  // base sram, 4 MB window
    localparam addr_t BASE_LIMIT = 32'h8080_0000;

    // fetches always read the whole word
    localparam mask_t MASK_FULL = 4'b1111;

    // where an address lands
    typedef enum logic [1:0] {
        TGT_NONE = 2'd0,   // unmapped, reads zero, writes dropped
        TGT_EXT  = 2'd1,   // ext bank
        TGT_BASE = 2'd2    // base bank
    } target_t;

endpackage
